/* project.f */
+incdir+.
logic/ppu_pkg.sv
logic/ppu_cfg_if.sv
logic/tile_row_if.sv
logic/ppu_regs.sv
logic/ppu_timing.sv
logic/bg_fetcher.sv
logic/pixel_shifter.sv
logic/ppu_top.sv
verif/ppu_chk.sv
verif/ppu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module ppu_tb -Mdir obj_dir -o ppu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ppu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
exit 1

/* verif/ppu_tb.sv */
`default_nettype none

`include "ppu_defines.svh"

module ppu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 10;
    localparam int CLK_PERIOD = 2 * HALF_PERIOD;
    localparam int FRAME_CYCLES = `PPU_LINE_CYCLES * `PPU_FRAME_LINES;
    localparam int WATCHDOG_NS = 5 * FRAME_CYCLES * CLK_PERIOD + 100_000;

    logic clk;
    logic rst;
    logic [15:0] addr;
    logic wr;
    logic [7:0] wdata;
    logic [7:0] rdata;
    logic irq_vblank;
    logic irq_lcdc;
    ppu_pkg::ppu_mode_t mode;
    logic vram_rd;
    logic [15:0] vram_addr;
    logic [7:0] vram_data;
    ppu_pkg::shade_t px_out;
    logic px_valid;

    logic [7:0] vram [0:8191]; // 8000-9FFF
    logic [31:0] rng_state = 32'd50280;

    // Display configuration as last written, used by the pixel reference
    logic [7:0] cfg_scx = 8'h00;
    logic [7:0] cfg_scy = 8'h00;
    logic [7:0] cfg_bgp = 8'h00;
    ppu_pkg::lcdc_t cfg_lcdc = '0;
    logic [7:0] cur_stat = 8'h00;

    // Timing reference, advanced on the rising edge
    logic active = 1'b0;
    logic lcd_on_ref = 1'b0;
    int dot_ref = 0;
    int line_ref = 0;

    // Monitor state
    int cyc = 0;
    int px_n = 0;
    int prev_vblank = -1;
    int vblank_cnt = 0;
    int lcdc_irq_cnt = 0;
    int frame_irqs = 0;
    int off_events = 0;
    ppu_pkg::ppu_mode_t exp_mode;

    ppu_top u_ppu_top (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr),
        .wr         (wr),
        .wdata      (wdata),
        .rdata      (rdata),
        .irq_vblank (irq_vblank),
        .irq_lcdc   (irq_lcdc),
        .mode       (mode),
        .vram_rd    (vram_rd),
        .vram_addr  (vram_addr),
        .vram_data  (vram_data),
        .px_out     (px_out),
        .px_valid   (px_valid)
    );

    assign vram_data = vram[vram_addr[12:0]]; // Same-cycle answer

    always #HALF_PERIOD clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] vram_byte(input int a);
        return vram[a[12:0]];
    endfunction

    // Shade of pixel n on line ly, straight from the background rules
    function automatic ppu_pkg::shade_t ref_pixel(input int ly, input int n,
                                                  input logic [7:0] scx, input logic [7:0] scy,
                                                  input ppu_pkg::lcdc_t lcdc,
                                                  input logic [7:0] bgp);
        int x;
        int y;
        int map_addr;
        int row_addr;
        logic [7:0] tile;
        logic [7:0] lo;
        logic [7:0] hi;
        logic [2:0] b;
        logic [1:0] idx;
        x = (int'(scx) + n) % 256;
        y = (ly + int'(scy)) % 256;
        map_addr = 'h9800 + (lcdc.bg_map ? 'h400 : 0) + (y / 8) * 32 + x / 8;
        tile = vram_byte(map_addr);
        if (lcdc.tile_sel)
            row_addr = 'h8000 + int'(tile) * 16;
        else
            row_addr = 'h9000 + int'($signed(tile)) * 16; // Tiles -128 to 127
        row_addr = row_addr + 2 * (y % 8);
        lo = vram_byte(row_addr);
        hi = vram_byte(row_addr + 1);
        b = 3'(7 - x % 8); // Bit 7 is leftmost
        idx = {hi[b], lo[b]};
        return ppu_pkg::shade_t'(bgp >> (2 * idx));
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            report_failure($sformatf("** Error %s: expected %02h, actual %02h", name, exp, act));
    endtask

    task automatic check_shade(input string name, input ppu_pkg::shade_t exp,
                               input ppu_pkg::shade_t act);
        if (act !== exp)
            report_failure($sformatf("** Error %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_mode(input string name, input ppu_pkg::ppu_mode_t exp,
                              input ppu_pkg::ppu_mode_t act);
        if (act !== exp)
            report_failure($sformatf("** Error %s: expected %s, actual %s",
                                     name, exp.name(), act.name()));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            report_failure($sformatf("** Error %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic write_reg(input logic [15:0] a, input logic [7:0] d);
        @(negedge clk);
        addr = a;
        wdata = d;
        wr = 1'b1;
        @(negedge clk);
        wr = 1'b0;
    endtask

    task automatic read_expect(input string name, input logic [15:0] a, input logic [7:0] exp);
        @(negedge clk);
        addr = a;
        wr = 1'b0;
        #5;
        check_byte(name, exp, rdata);
    endtask

    task automatic draw_byte(output logic [7:0] b);
        rng_state = xorshift(rng_state);
        b = rng_state[7:0];
    endtask

    // Writes taken at the edge, as the register file sees them
    always @(posedge clk)
    begin
        active <= !rst;
        if (rst)
        begin
            lcd_on_ref <= 1'b0;
            dot_ref <= 0;
            line_ref <= 0;
        end
        else
        begin
            if (wr && addr == `PPU_ADDR_LCDC)
                lcd_on_ref <= wdata[7];
            if (!lcd_on_ref)
            begin
                dot_ref <= 0;
                line_ref <= 0;
            end
            else if (dot_ref == `PPU_LINE_CYCLES - 1)
            begin
                dot_ref <= 0;
                line_ref <= (line_ref == `PPU_FRAME_LINES - 1) ? 0 : line_ref + 1;
            end
            else
                dot_ref <= dot_ref + 1;
        end
    end

    // Outputs settle by mid-cycle, so compare on the falling edge
    always @(negedge clk)
    begin
        if (active)
        begin
            cyc = cyc + 1;
            if (!lcd_on_ref)
            begin
                check_mode("mode with LCD off", ppu_pkg::HBLANK, mode);
                if (px_valid)
                    off_events = off_events + 1;
                if (vram_rd)
                    off_events = off_events + 1;
                prev_vblank = -1;
            end
            else
            begin
                if (line_ref >= `PPU_SCREEN_H)
                    exp_mode = ppu_pkg::VBLANK;
                else if (dot_ref < `PPU_OAM_CYCLES)
                    exp_mode = ppu_pkg::OAM;
                else if (px_n < `PPU_SCREEN_W)
                    exp_mode = ppu_pkg::RENDER;
                else
                    exp_mode = ppu_pkg::HBLANK;
                check_mode($sformatf("mode line %0d dot %0d", line_ref, dot_ref), exp_mode, mode);

                if (px_valid)
                begin
                    check_shade($sformatf("pixel line %0d x %0d", line_ref, px_n),
                                ref_pixel(line_ref, px_n, cfg_scx, cfg_scy, cfg_lcdc, cfg_bgp),
                                px_out);
                    px_n = px_n + 1;
                end

                if (irq_vblank)
                begin
                    check_count("v-blank pulse line", `PPU_SCREEN_H, line_ref);
                    check_count("v-blank pulse dot", 0, dot_ref);
                    if (prev_vblank >= 0)
                        check_count("cycles between v-blank pulses", FRAME_CYCLES,
                                    cyc - prev_vblank);
                    prev_vblank = cyc;
                    frame_irqs = lcdc_irq_cnt; // One frame of STAT pulses
                    lcdc_irq_cnt = 0;
                    vblank_cnt = vblank_cnt + 1;
                end

                if (irq_lcdc)
                begin
                    lcdc_irq_cnt = lcdc_irq_cnt + 1;
                    if (cur_stat == 8'h40)
                        check_count("LY at LYC interrupt", 37, line_ref);
                end

                if (dot_ref == `PPU_LINE_CYCLES - 1)
                begin
                    check_count($sformatf("pixels on line %0d", line_ref),
                                (line_ref < `PPU_SCREEN_H) ? `PPU_SCREEN_W : 0, px_n);
                    px_n = 0;
                end
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        report_failure("Timeout: the test sequence did not reach its end in time");
    end

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        addr = 16'h0000;
        wr = 1'b0;
        wdata = 8'h00;
        for (int i = 0; i < 8192; i++)
        begin
            rng_state = xorshift(rng_state);
            vram[13'(i)] = rng_state[7:0];
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Register access, LCD still off
        write_reg(`PPU_ADDR_LCDC, 8'h7F);
        write_reg(`PPU_ADDR_SCY, 8'h5A);
        write_reg(`PPU_ADDR_SCX, 8'hA5);
        write_reg(`PPU_ADDR_LYC, 8'h6C);
        write_reg(`PPU_ADDR_BGP, 8'hE4);
        read_expect("LCDC readback", `PPU_ADDR_LCDC, 8'h7F);
        read_expect("SCY readback", `PPU_ADDR_SCY, 8'h5A);
        read_expect("SCX readback", `PPU_ADDR_SCX, 8'hA5);
        read_expect("LYC readback", `PPU_ADDR_LYC, 8'h6C);
        read_expect("BGP readback", `PPU_ADDR_BGP, 8'hE4);
        write_reg(`PPU_ADDR_STAT, 8'hFF);
        read_expect("STAT all enables", `PPU_ADDR_STAT, 8'hF8); // Low bits read-only
        write_reg(`PPU_ADDR_STAT, 8'h07);
        read_expect("STAT no enables", `PPU_ADDR_STAT, 8'h80);
        write_reg(`PPU_ADDR_LY, 8'h55);
        read_expect("LY ignores writes", `PPU_ADDR_LY, 8'h00);
        read_expect("unmapped FF46", 16'hFF46, 8'hFF);

        // LCD off for two line lengths
        repeat (2 * `PPU_LINE_CYCLES) @(negedge clk);
        read_expect("LY with LCD off", `PPU_ADDR_LY, 8'h00);
        check_count("pixels and VRAM reads with LCD off", 0, off_events);

        // Frame 0, unsigned tiles from map 0
        draw_byte(cfg_scx);
        draw_byte(cfg_scy);
        draw_byte(cfg_bgp);
        cfg_lcdc = ppu_pkg::lcdc_t'(8'h91);
        write_reg(`PPU_ADDR_SCX, cfg_scx);
        write_reg(`PPU_ADDR_SCY, cfg_scy);
        write_reg(`PPU_ADDR_BGP, cfg_bgp);
        write_reg(`PPU_ADDR_LCDC, cfg_lcdc);
        wait (vblank_cnt == 1);
        read_expect("LY in v-blank", `PPU_ADDR_LY, 8'd144);
        read_expect("STAT in v-blank", `PPU_ADDR_STAT, 8'h81);

        // Frame 1, signed tiles from map 1, LYC interrupt armed
        draw_byte(cfg_scx);
        draw_byte(cfg_scy);
        draw_byte(cfg_bgp);
        cfg_lcdc = ppu_pkg::lcdc_t'(8'h89);
        write_reg(`PPU_ADDR_SCX, cfg_scx);
        write_reg(`PPU_ADDR_SCY, cfg_scy);
        write_reg(`PPU_ADDR_BGP, cfg_bgp);
        write_reg(`PPU_ADDR_LCDC, cfg_lcdc);
        write_reg(`PPU_ADDR_LYC, 8'd37);
        cur_stat = 8'h40;
        write_reg(`PPU_ADDR_STAT, cur_stat);
        wait (vblank_cnt == 2);
        check_count("LYC interrupts per frame", 1, frame_irqs);

        // Frame 2, h-blank interrupt only
        cur_stat = 8'h08;
        write_reg(`PPU_ADDR_STAT, cur_stat);
        wait (vblank_cnt == 3);
        check_count("h-blank interrupts per frame", `PPU_SCREEN_H, frame_irqs);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/ppu_chk.sv */
`default_nettype none

`include "ppu_defines.svh"

module ppu_chk (
    input  logic clk,
    input  logic rst,
    input  logic [15:0] addr,
    input  logic wr,
    input  logic [7:0] wdata,
    input  ppu_pkg::ppu_mode_t mode,
    input  logic irq_vblank,
    input  logic vram_rd,
    input  logic [15:0] vram_addr,
    input  logic px_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    logic lcd_on_seen; // LCDC bit 7 as last written

    always_ff @(posedge clk)
    begin
        if (rst)
            lcd_on_seen <= 1'b0;
        else if (wr && addr == `PPU_ADDR_LCDC)
            lcd_on_seen <= wdata[7];
    end

    px_in_render: assert property (@(posedge clk) disable iff (rst)
        px_valid |-> mode == ppu_pkg::RENDER)
        else $error("px_valid outside RENDER mode");

    vblank_single: assert property (@(posedge clk) disable iff (rst)
        irq_vblank |=> !irq_vblank)
        else $error("irq_vblank longer than one cycle");

    vram_in_range: assert property (@(posedge clk) disable iff (rst)
        vram_rd |-> (vram_addr >= 16'h8000 && vram_addr <= 16'h9FFF))
        else $error("VRAM read outside 8000-9FFF");

    // Off keeps HBLANK, switching on starts line 0 in OAM
    off_in_hblank: assert property (@(posedge clk) disable iff (rst)
        !lcd_on_seen |=> mode == (lcd_on_seen ? ppu_pkg::OAM : ppu_pkg::HBLANK))
        else $error("mode wrong while the LCD is off or just switched on");

endmodule

bind ppu_top ppu_chk u_chk (
    .clk        (clk),
    .rst        (rst),
    .addr       (addr),
    .wr         (wr),
    .wdata      (wdata),
    .mode       (mode),
    .irq_vblank (irq_vblank),
    .vram_rd    (vram_rd),
    .vram_addr  (vram_addr),
    .px_valid   (px_valid)
);

`default_nettype wire

/* logic/ppu_top.sv */
`default_nettype none

module ppu_top (
    input  logic clk,
    input  logic rst,
    input  logic [15:0] addr,
    input  logic wr,
    input  logic [7:0] wdata,
    output logic [7:0] rdata,
    output logic irq_vblank,
    output logic irq_lcdc,
    output ppu_pkg::ppu_mode_t mode,
    output logic vram_rd,
    output logic [15:0] vram_addr,
    input  logic [7:0] vram_data,
    output ppu_pkg::shade_t px_out,
    output logic px_valid
);

    logic rendering;
    logic line_done;
    logic [7:0] ly;

    ppu_cfg_if u_cfg ();
    tile_row_if u_row ();

    ppu_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .wr       (wr),
        .wdata    (wdata),
        .ly       (ly),
        .mode     (mode),
        .rdata    (rdata),
        .irq_lcdc (irq_lcdc),
        .cfg      (u_cfg.regs)
    );

    ppu_timing u_timing (
        .clk        (clk),
        .rst        (rst),
        .line_done  (line_done),
        .rendering  (rendering),
        .ly         (ly),
        .mode       (mode),
        .irq_vblank (irq_vblank),
        .cfg        (u_cfg.timing)
    );

    // VRAM side of the background path
    bg_fetcher u_fetcher (
        .clk       (clk),
        .rst       (rst),
        .rendering (rendering),
        .ly        (ly),
        .vram_data (vram_data),
        .vram_rd   (vram_rd),
        .vram_addr (vram_addr),
        .cfg       (u_cfg.fetcher),
        .row       (u_row.fetcher)
    );

    pixel_shifter u_shifter (
        .clk       (clk),
        .rst       (rst),
        .rendering (rendering),
        .px_out    (px_out),
        .px_valid  (px_valid),
        .line_done (line_done),
        .cfg       (u_cfg.shifter),
        .row       (u_row.shifter)
    );

endmodule

`default_nettype wire

/* logic/pixel_shifter.sv */
`default_nettype none

`include "ppu_defines.svh"

module pixel_shifter (
    input  logic clk,
    input  logic rst,
    input  logic rendering,
    output ppu_pkg::shade_t px_out,
    output logic px_valid,
    output logic line_done,
    ppu_cfg_if.shifter cfg,
    tile_row_if.shifter row
);

    logic [15:0] buf_a; // {hi, lo}
    logic [15:0] buf_b;
    logic valid_a;
    logic valid_b;
    logic sel;          // Selected buffer shifts, the other loads
    logic [2:0] shift_cnt;
    logic [2:0] skip;   // Fine scroll left to drop
    logic [7:0] px_cnt;
    logic [15:0] cur;
    logic shift_en;
    ppu_pkg::shade_t color_idx;

    function automatic logic [15:0] shift_row(input logic [15:0] r);
        return {r[14:8], 1'b0, r[6:0], 1'b0};
    endfunction

    assign cur = sel ? buf_b : buf_a;
    assign shift_en = rendering && (sel ? valid_b : valid_a);
    assign color_idx = {cur[15], cur[7]};

    assign px_valid = shift_en && (skip == 3'd0);
    assign px_out = {cfg.bgp[{color_idx, 1'b1}], cfg.bgp[{color_idx, 1'b0}]};
    assign line_done = px_valid && (px_cnt == 8'(`PPU_SCREEN_W - 1));
    assign row.row_free = !valid_a || !valid_b;

    always_ff @(posedge clk)
    begin
        if (row.row_load && sel)
            buf_a <= {row.row_hi, row.row_lo};
        else if (shift_en && !sel)
            buf_a <= shift_row(buf_a);

        if (row.row_load && !sel)
            buf_b <= {row.row_hi, row.row_lo};
        else if (shift_en && sel)
            buf_b <= shift_row(buf_b);
    end

    always_ff @(posedge clk)
    begin
        if (rst || !rendering)
        begin
            valid_a <= 1'b0;
            valid_b <= 1'b0;
            sel <= 1'b0;
            shift_cnt <= 3'd0;
            skip <= cfg.scx[2:0];
            px_cnt <= 8'd0;
        end
        else
        begin
            if (row.row_load)
            begin
                if (sel)
                    valid_a <= 1'b1;
                else
                    valid_b <= 1'b1;
                // Both empty, make the new row the shifting one
                if (!valid_a && !valid_b)
                    sel <= !sel;
            end
            if (shift_en)
            begin
                shift_cnt <= shift_cnt + 3'd1;
                if (skip != 3'd0)
                    skip <= skip - 3'd1;
                else
                    px_cnt <= px_cnt + 8'd1;
                if (shift_cnt == 3'd7) // Last pixel of this row
                begin
                    if (sel)
                        valid_b <= 1'b0;
                    else
                        valid_a <= 1'b0;
                    sel <= !sel;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/bg_fetcher.sv */
`default_nettype none

`include "ppu_defines.svh"

module bg_fetcher (
    input  logic clk,
    input  logic rst,
    input  logic rendering,
    input  logic [7:0] ly,
    input  logic [7:0] vram_data,
    output logic vram_rd,
    output logic [15:0] vram_addr,
    ppu_cfg_if.fetcher cfg,
    tile_row_if.fetcher row
);

    logic [1:0] phase;    // 0 map byte, 1 low byte, 2 high byte
    logic [4:0] col;      // Tile column in the map
    logic [7:0] tile_num;
    logic [7:0] y;        // Background line
    logic start;
    logic [15:0] map_addr;
    logic [15:0] tile_base;

    assign y = ly + cfg.scy;

    // No new tile while a load is in flight, row_free is stale then
    assign start = rendering && row.row_free && !row.row_load && (phase == 2'd0);
    assign vram_rd = start || (rendering && phase != 2'd0);

    assign map_addr = `PPU_MAP_BASE + {5'b0, cfg.lcdc.bg_map, y[7:3], col};

    // Signed numbers reach down to 8800
    assign tile_base = cfg.lcdc.tile_sel
                     ? `PPU_TILE_BASE_LO + {4'b0, tile_num, 4'b0}
                     : `PPU_TILE_BASE_HI + {{4{tile_num[7]}}, tile_num, 4'b0};

    always_comb
    begin
        case (phase)
            2'd1:    vram_addr = tile_base | {12'b0, y[2:0], 1'b0};
            2'd2:    vram_addr = tile_base | {12'b0, y[2:0], 1'b1};
            default: vram_addr = map_addr;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst || !rendering)
        begin
            phase <= 2'd0;
            col <= cfg.scx[7:3]; // First column of the next line
            row.row_load <= 1'b0;
        end
        else
        begin
            row.row_load <= 1'b0;
            case (phase)
                2'd0: if (start) phase <= 2'd1;
                2'd1: phase <= 2'd2;
                default:
                begin
                    phase <= 2'd0;
                    row.row_load <= 1'b1;
                    col <= col + 5'd1; // Wraps at 32
                end
            endcase
        end
    end

    // Read data capture
    always_ff @(posedge clk)
    begin
        if (vram_rd)
        begin
            case (phase)
                2'd0:    tile_num <= vram_data;
                2'd1:    row.row_lo <= vram_data;
                default: row.row_hi <= vram_data;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/ppu_timing.sv */
`default_nettype none

`include "ppu_defines.svh"

module ppu_timing (
    input  logic clk,
    input  logic rst,
    input  logic line_done,
    output logic rendering,
    output logic [7:0] ly,
    output ppu_pkg::ppu_mode_t mode,
    output logic irq_vblank,
    ppu_cfg_if.timing cfg
);

    logic [8:0] dot;
    ppu_pkg::ppu_mode_t state;
    logic last_dot;

    assign last_dot = (dot == 9'(`PPU_LINE_CYCLES - 1));

    // State waits in OAM while off, so line 0 starts right away
    assign mode = cfg.lcdc.lcd_on ? state : ppu_pkg::HBLANK;
    assign rendering = (mode == ppu_pkg::RENDER);

    always_ff @(posedge clk)
    begin
        if (rst || !cfg.lcdc.lcd_on)
        begin
            dot <= 9'd0;
            ly <= 8'd0;
            state <= ppu_pkg::OAM;
            irq_vblank <= 1'b0;
        end
        else
        begin
            irq_vblank <= 1'b0;
            dot <= last_dot ? 9'd0 : dot + 9'd1;

            case (state)
                ppu_pkg::OAM:
                begin
                    if (dot == 9'(`PPU_OAM_CYCLES - 1))
                        state <= ppu_pkg::RENDER;
                end
                ppu_pkg::RENDER:
                begin
                    if (line_done)
                        state <= ppu_pkg::HBLANK; // Length set by the pixel stream
                end
                default: ;
            endcase

            // End of line
            if (last_dot)
            begin
                if (ly == 8'(`PPU_FRAME_LINES - 1))
                begin
                    ly <= 8'd0;
                    state <= ppu_pkg::OAM;
                end
                else
                begin
                    ly <= ly + 8'd1;
                    if (ly == 8'(`PPU_SCREEN_H - 1))
                    begin
                        state <= ppu_pkg::VBLANK;
                        irq_vblank <= 1'b1; // High while LY first reads 144
                    end
                    else if (ly < 8'(`PPU_SCREEN_H - 1))
                        state <= ppu_pkg::OAM;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/ppu_regs.sv */
`default_nettype none

`include "ppu_defines.svh"

module ppu_regs (
    input  logic clk,
    input  logic rst,
    input  logic [15:0] addr,
    input  logic wr,
    input  logic [7:0] wdata,
    input  logic [7:0] ly,
    input  ppu_pkg::ppu_mode_t mode,
    output logic [7:0] rdata,
    output logic irq_lcdc,
    ppu_cfg_if.regs cfg
);

    ppu_pkg::lcdc_t lcdc;
    ppu_pkg::stat_en_t stat_en;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    logic [7:0] bgp;
    logic lyc_match;
    logic stat_cond;
    logic stat_q; // Condition one cycle ago

    assign cfg.lcdc = lcdc;
    assign cfg.scx = scx;
    assign cfg.scy = scy;
    assign cfg.bgp = bgp;

    assign lyc_match = (ly == lyc);

    // Combined STAT source, all off while the LCD is off
    assign stat_cond = lcdc.lcd_on &&
                       ((stat_en.lyc_en && lyc_match) ||
                        (stat_en.hblank_en && mode == ppu_pkg::HBLANK) ||
                        (stat_en.oam_en && mode == ppu_pkg::OAM) ||
                        (stat_en.vblank_en && mode == ppu_pkg::VBLANK));

    assign irq_lcdc = stat_cond && !stat_q; // Rising edge only

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lcdc <= '0;
            stat_en <= '0;
            scy <= 8'h00;
            scx <= 8'h00;
            lyc <= 8'h00;
            bgp <= 8'h00;
            stat_q <= 1'b0;
        end
        else
        begin
            stat_q <= stat_cond;
            if (wr)
            begin
                case (addr)
                    `PPU_ADDR_LCDC: lcdc <= ppu_pkg::lcdc_t'(wdata);
                    `PPU_ADDR_STAT: stat_en <= ppu_pkg::stat_en_t'(wdata[6:3]); // Low bits read-only
                    `PPU_ADDR_SCY:  scy <= wdata;
                    `PPU_ADDR_SCX:  scx <= wdata;
                    `PPU_ADDR_LYC:  lyc <= wdata;
                    `PPU_ADDR_BGP:  bgp <= wdata;
                    default: ;
                endcase
            end
        end
    end

    always_comb
    begin
        case (addr)
            `PPU_ADDR_LCDC: rdata = lcdc;
            `PPU_ADDR_STAT: rdata = {1'b1, stat_en, lyc_match, mode};
            `PPU_ADDR_SCY:  rdata = scy;
            `PPU_ADDR_SCX:  rdata = scx;
            `PPU_ADDR_LY:   rdata = ly;
            `PPU_ADDR_LYC:  rdata = lyc;
            `PPU_ADDR_BGP:  rdata = bgp;
            default:        rdata = 8'hFF;
        endcase
    end

endmodule

`default_nettype wire

/* logic/tile_row_if.sv */
`default_nettype none

// One tile row per row_load pulse, leftmost pixel in bit 7
interface tile_row_if;

    logic [7:0] row_lo;
    logic [7:0] row_hi;
    logic row_load;
    logic row_free; // A buffer is empty

    modport fetcher (output row_lo, output row_hi, output row_load, input row_free);
    modport shifter (input row_lo, input row_hi, input row_load, output row_free);

endinterface

`default_nettype wire

/* logic/ppu_cfg_if.sv */
`default_nettype none

// Live display configuration from the register file
interface ppu_cfg_if;

    ppu_pkg::lcdc_t lcdc;
    logic [7:0] scx;
    logic [7:0] scy;
    logic [7:0] bgp;

    modport regs (output lcdc, output scx, output scy, output bgp);
    modport timing (input lcdc);
    modport fetcher (input lcdc, input scx, input scy);
    modport shifter (input scx, input bgp);

endinterface

`default_nettype wire

/* logic/ppu_pkg.sv */
`default_nettype none

package ppu_pkg;

    // Encoding matches the STAT mode field
    typedef enum logic [1:0] {
        HBLANK = 2'd0,
        VBLANK = 2'd1,
        OAM    = 2'd2,
        RENDER = 2'd3
    } ppu_mode_t;

    typedef struct packed {
        logic lcd_on;   // Bit 7
        logic win_map;
        logic win_on;
        logic tile_sel; // 1 selects 8000 unsigned
        logic bg_map;   // 1 selects map 1
        logic obj_size;
        logic obj_on;
        logic bg_on;    // Bit 0
    } lcdc_t;

    // STAT bits 6 down to 3
    typedef struct packed {
        logic lyc_en;
        logic oam_en;
        logic vblank_en;
        logic hblank_en;
    } stat_en_t;

    typedef logic [1:0] shade_t;

endpackage

`default_nettype wire

/* ppu_defines.svh */
`ifndef PPU_DEFINES_SVH
`define PPU_DEFINES_SVH

// Line and frame timing, in dots
`define PPU_LINE_CYCLES 456
`define PPU_OAM_CYCLES 80
`define PPU_FRAME_LINES 154

// Visible area
`define PPU_SCREEN_W 160
`define PPU_SCREEN_H 144

// MMIO register map
`define PPU_ADDR_LCDC 16'hFF40
`define PPU_ADDR_STAT 16'hFF41
`define PPU_ADDR_SCY 16'hFF42
`define PPU_ADDR_SCX 16'hFF43
`define PPU_ADDR_LY 16'hFF44
`define PPU_ADDR_LYC 16'hFF45
`define PPU_ADDR_BGP 16'hFF47

`define PPU_MAP_BASE 16'h9800     // Map 1 sits 0x400 above
`define PPU_TILE_BASE_LO 16'h8000 // Unsigned tile numbers
`define PPU_TILE_BASE_HI 16'h9000 // Signed tile numbers

`endif
